// ==== frame_pkg.sv ====
`default_nettype none

package frame_pkg;

  // Stream data width, fixed by the header byte layout
  localparam int byte_width = 8;

  typedef enum logic [1:0] {
    KIND_PLAIN    = 2'd0,
    KIND_TAGGED   = 2'd1,
    KIND_PRIORITY = 2'd2
  } hdr_kind_t;

  // Payload beats after the header, 0 to 63
  typedef logic [5:0] hdr_len_t;

  typedef struct packed {
    hdr_kind_t kind;
    hdr_len_t  len;
  } frame_hdr_fields_t;

  // First beat of a frame, seen as a raw byte or as kind and length
  typedef union packed {
    logic [byte_width-1:0] raw;
    frame_hdr_fields_t     fields;
  } frame_hdr_u;

  typedef logic [byte_width-1:0] sum_t;

endpackage

`default_nettype wire

// ==== frame_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_gen (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               cmd_valid,
  input  wire frame_pkg::hdr_kind_t         cmd_kind,
  input  wire frame_pkg::hdr_len_t          cmd_len,
  input  wire [frame_pkg::byte_width-1:0]   cmd_seed,
  input  wire                               cmd_bad,
  input  wire                               m_tready,
  output logic                              gen_busy,
  output logic [frame_pkg::byte_width-1:0]  m_tdata,
  output logic                              m_tvalid,
  output logic                              m_tlast,
  output logic                              m_tuser
);

  frame_pkg::frame_hdr_u             hdr_next;
  frame_pkg::hdr_len_t               len_q;
  frame_pkg::hdr_len_t               cnt;
  frame_pkg::hdr_len_t               cnt_next;
  logic [frame_pkg::byte_width-1:0]  data_q;
  logic                              bad_q;
  logic                              accept;
  logic                              xfer;

  assign accept   = cmd_valid & ~gen_busy;
  assign xfer     = m_tvalid & m_tready;
  assign cnt_next = cnt + 6'd1;

  always_comb begin
    hdr_next.fields.kind = cmd_kind;
    hdr_next.fields.len  = cmd_len;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gen_busy <= 1'b0;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
      m_tuser  <= 1'b0;
    end else if (accept) begin
      // Header goes out first; a zero-length frame ends on it
      gen_busy <= 1'b1;
      m_tvalid <= 1'b1;
      m_tdata  <= hdr_next.raw;
      m_tlast  <= (cmd_len == 6'd0);
      m_tuser  <= cmd_bad & (cmd_len == 6'd0);
      len_q    <= cmd_len;
      data_q   <= cmd_seed;
      bad_q    <= cmd_bad;
      cnt      <= '0;
    end else if (xfer) begin
      if (m_tlast) begin
        gen_busy <= 1'b0;
        m_tvalid <= 1'b0;
        m_tlast  <= 1'b0;
        m_tuser  <= 1'b0;
      end else begin
        m_tdata <= data_q;
        data_q  <= data_q + 8'd1;
        cnt     <= cnt_next;
        m_tlast <= (cnt_next == len_q);
        m_tuser <= bad_q & (cnt_next == len_q);
      end
    end
  end

endmodule

`default_nettype wire

// ==== axis_frame_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_frame_fifo #(
  parameter int ADDR_WIDTH     = 4,
  parameter bit DROP_WHEN_FULL = 1'b1
) (
  input  wire                               clk,
  input  wire                               rst,
  input  wire [frame_pkg::byte_width-1:0]   input_axis_tdata,
  input  wire                               input_axis_tvalid,
  output logic                              input_axis_tready,
  input  wire                               input_axis_tlast,
  input  wire                               input_axis_tuser,
  output logic [frame_pkg::byte_width-1:0]  output_axis_tdata,
  output logic                              output_axis_tvalid,
  input  wire                               output_axis_tready,
  output logic                              output_axis_tlast,
  output logic                              drop_frame
);

  localparam int depth      = 2 ** ADDR_WIDTH;
  localparam int word_width = frame_pkg::byte_width + 1;

  logic [ADDR_WIDTH:0]   wr_ptr;
  logic [ADDR_WIDTH:0]   wr_ptr_cur;
  logic [ADDR_WIDTH:0]   rd_ptr;
  logic [word_width-1:0] mem [depth];
  logic [word_width-1:0] data_in;
  logic [word_width-1:0] data_out_reg;
  logic                  full;
  logic                  full_cur;
  logic                  empty;
  logic                  write;
  logic                  store;
  logic                  read;

  assign data_in = {input_axis_tlast, input_axis_tdata};

  // No free entry left behind the frame being written
  assign full = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
  // Current frame already spans the whole memory
  assign full_cur = (wr_ptr[ADDR_WIDTH] != wr_ptr_cur[ADDR_WIDTH]) &&
                    (wr_ptr[ADDR_WIDTH-1:0] == wr_ptr_cur[ADDR_WIDTH-1:0]);
  // Only committed frames are visible to the read side
  assign empty = (wr_ptr == rd_ptr);

  assign input_axis_tready = ~full | DROP_WHEN_FULL;
  assign write = input_axis_tvalid & input_axis_tready;
  assign store = write & ~(full | full_cur | drop_frame);
  assign read  = (output_axis_tready | ~output_axis_tvalid) & ~empty;

  assign {output_axis_tlast, output_axis_tdata} = data_out_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
    end else if (write) begin
      if (!store) begin
        // Discard the rest of the frame, then roll back to the last commit
        drop_frame <= 1'b1;
        if (input_axis_tlast) begin
          wr_ptr_cur <= wr_ptr;
          drop_frame <= 1'b0;
        end
      end else begin
        wr_ptr_cur <= wr_ptr_cur + 1'b1;
        if (input_axis_tlast) begin
          if (input_axis_tuser) begin
            wr_ptr_cur <= wr_ptr;
          end else begin
            wr_ptr <= wr_ptr_cur + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (read) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      data_out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  // Output stage holds its beat until the sink takes it
  always_ff @(posedge clk) begin
    if (rst) begin
      output_axis_tvalid <= 1'b0;
    end else if (output_axis_tready | ~output_axis_tvalid) begin
      output_axis_tvalid <= ~empty;
    end
  end

endmodule

`default_nettype wire

// ==== frame_sink.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_sink (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire [frame_pkg::byte_width-1:0]         s_tdata,
  input  wire                                     s_tvalid,
  input  wire                                     s_tlast,
  input  wire                                     s_ready_in,
  output logic                                    s_tready,
  output logic                                    res_valid,
  output frame_pkg::hdr_kind_t                    res_kind,
  output logic [frame_pkg::byte_width-1:0]        res_hdr_raw,
  output frame_pkg::hdr_len_t                     res_len,
  output logic [$bits(frame_pkg::hdr_len_t):0]    res_count,
  output frame_pkg::sum_t                         res_sum,
  output logic                                    res_len_err
);

  localparam int cnt_width = $bits(frame_pkg::hdr_len_t) + 1;

  frame_pkg::frame_hdr_u   hdr_q;
  frame_pkg::frame_hdr_u   hdr_cur;
  logic [cnt_width-1:0]    count;
  logic [cnt_width-1:0]    count_next;
  frame_pkg::sum_t         sum;
  frame_pkg::sum_t         sum_next;
  logic                    in_frame;
  logic                    xfer;

  assign s_tready = s_ready_in;
  assign xfer     = s_tvalid & s_tready;

  // Header of the frame in progress, or the beat itself when it is the header
  always_comb begin
    hdr_cur.raw = in_frame ? hdr_q.raw : s_tdata;
    count_next  = in_frame ? count + 1'b1 : '0;
    sum_next    = in_frame ? sum + s_tdata : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= xfer & s_tlast;
      if (xfer) begin
        in_frame <= ~s_tlast;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      if (!in_frame) begin
        hdr_q <= hdr_cur;
      end
      count <= count_next;
      sum   <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && s_tlast) begin
      res_kind    <= hdr_cur.fields.kind;
      res_hdr_raw <= hdr_cur.raw;
      res_len     <= hdr_cur.fields.len;
      res_count   <= count_next;
      res_sum     <= sum_next;
      res_len_err <= count_next != {1'b0, hdr_cur.fields.len};
    end
  end

endmodule

`default_nettype wire

// ==== frame_path.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_path #(
  parameter int ADDR_WIDTH     = 4,
  parameter bit DROP_WHEN_FULL = 1'b1
) (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire                                     cmd_valid,
  input  wire frame_pkg::hdr_kind_t               cmd_kind,
  input  wire frame_pkg::hdr_len_t                cmd_len,
  input  wire [frame_pkg::byte_width-1:0]         cmd_seed,
  input  wire                                     cmd_bad,
  input  wire                                     sink_ready,
  output logic                                    gen_busy,
  output logic                                    drop_frame,
  output logic                                    res_valid,
  output frame_pkg::hdr_kind_t                    res_kind,
  output logic [frame_pkg::byte_width-1:0]        res_hdr_raw,
  output frame_pkg::hdr_len_t                     res_len,
  output logic [$bits(frame_pkg::hdr_len_t):0]    res_count,
  output frame_pkg::sum_t                         res_sum,
  output logic                                    res_len_err
);

  logic [frame_pkg::byte_width-1:0] gen_tdata;
  logic                             gen_tvalid;
  logic                             gen_tready;
  logic                             gen_tlast;
  logic                             gen_tuser;
  logic [frame_pkg::byte_width-1:0] fifo_tdata;
  logic                             fifo_tvalid;
  logic                             fifo_tready;
  logic                             fifo_tlast;

  frame_gen u_gen (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_kind  (cmd_kind),
    .cmd_len   (cmd_len),
    .cmd_seed  (cmd_seed),
    .cmd_bad   (cmd_bad),
    .m_tready  (gen_tready),
    .gen_busy  (gen_busy),
    .m_tdata   (gen_tdata),
    .m_tvalid  (gen_tvalid),
    .m_tlast   (gen_tlast),
    .m_tuser   (gen_tuser)
  );

  axis_frame_fifo #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DROP_WHEN_FULL (DROP_WHEN_FULL)
  ) u_fifo (
    .clk                (clk),
    .rst                (rst),
    .input_axis_tdata   (gen_tdata),
    .input_axis_tvalid  (gen_tvalid),
    .input_axis_tready  (gen_tready),
    .input_axis_tlast   (gen_tlast),
    .input_axis_tuser   (gen_tuser),
    .output_axis_tdata  (fifo_tdata),
    .output_axis_tvalid (fifo_tvalid),
    .output_axis_tready (fifo_tready),
    .output_axis_tlast  (fifo_tlast),
    .drop_frame         (drop_frame)
  );

  frame_sink u_sink (
    .clk         (clk),
    .rst         (rst),
    .s_tdata     (fifo_tdata),
    .s_tvalid    (fifo_tvalid),
    .s_tlast     (fifo_tlast),
    .s_ready_in  (sink_ready),
    .s_tready    (fifo_tready),
    .res_valid   (res_valid),
    .res_kind    (res_kind),
    .res_hdr_raw (res_hdr_raw),
    .res_len     (res_len),
    .res_count   (res_count),
    .res_sum     (res_sum),
    .res_len_err (res_len_err)
  );

endmodule

`default_nettype wire

// ==== frame_path_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_path_sva #(
  parameter int ADDR_WIDTH = 4
) (
  input wire                             clk,
  input wire                             rst,
  input wire [frame_pkg::byte_width-1:0] output_axis_tdata,
  input wire                             output_axis_tvalid,
  input wire                             output_axis_tready,
  input wire                             output_axis_tlast,
  input wire [ADDR_WIDTH:0]              wr_ptr,
  input wire [ADDR_WIDTH:0]              rd_ptr
);

  // Stalled output beat keeps its data and last flag
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (output_axis_tvalid && !output_axis_tready) |=>
      (output_axis_tvalid && $stable(output_axis_tdata) && $stable(output_axis_tlast)))
    else $error("output beat changed while stalled");

  a_reset_idle: assert property (@(posedge clk) rst |=> !output_axis_tvalid)
    else $error("output valid high after reset");

  // Read pointer must not move past the committed write pointer
  a_no_empty_read: assert property (@(posedge clk) disable iff (rst)
    (wr_ptr == rd_ptr) |=> (rd_ptr == $past(rd_ptr)))
    else $error("read from an empty FIFO");

endmodule

bind axis_frame_fifo frame_path_sva #(.ADDR_WIDTH(ADDR_WIDTH)) i_sva (
  .clk                (clk),
  .rst                (rst),
  .output_axis_tdata  (output_axis_tdata),
  .output_axis_tvalid (output_axis_tvalid),
  .output_axis_tready (output_axis_tready),
  .output_axis_tlast  (output_axis_tlast),
  .wr_ptr             (wr_ptr),
  .rd_ptr             (rd_ptr)
);

`default_nettype wire

// ==== tb_frame_path.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_frame_path;

  // Beats of every test with the random frames counted at their longest
  localparam int test_beats     = 120 + 15 + 24 + 14 + 30 * 16;
  localparam int timeout_cycles = test_beats * 4 + 1500;

  logic                             clk        = 1'b0;
  logic                             rst        = 1'b1;
  logic                             cmd_valid  = 1'b0;
  frame_pkg::hdr_kind_t             cmd_kind   = frame_pkg::KIND_PLAIN;
  frame_pkg::hdr_len_t              cmd_len    = '0;
  logic [frame_pkg::byte_width-1:0] cmd_seed   = '0;
  logic                             cmd_bad    = 1'b0;
  logic                             sink_ready = 1'b0;
  logic [1:0]                       ready_mode = 2'd1;
  int                               cycle_count = 0;

  logic                                 gen_busy;
  logic                                 drop_frame;
  logic                                 res_valid;
  frame_pkg::hdr_kind_t                 res_kind;
  logic [frame_pkg::byte_width-1:0]     res_hdr_raw;
  frame_pkg::hdr_len_t                  res_len;
  logic [$bits(frame_pkg::hdr_len_t):0] res_count;
  frame_pkg::sum_t                      res_sum;
  logic                                 res_len_err;

  // Expected results as {raw header, checksum}
  logic [15:0] exp_q [$];
  logic [15:0] head;

  frame_path #(
    .ADDR_WIDTH     (4),
    .DROP_WHEN_FULL (1'b1)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_kind    (cmd_kind),
    .cmd_len     (cmd_len),
    .cmd_seed    (cmd_seed),
    .cmd_bad     (cmd_bad),
    .sink_ready  (sink_ready),
    .gen_busy    (gen_busy),
    .drop_frame  (drop_frame),
    .res_valid   (res_valid),
    .res_kind    (res_kind),
    .res_hdr_raw (res_hdr_raw),
    .res_len     (res_len),
    .res_count   (res_count),
    .res_sum     (res_sum),
    .res_len_err (res_len_err)
  );

  always #20 clk = ~clk;

  function automatic logic [15:0] expect_result(frame_pkg::hdr_kind_t kind,
                                                frame_pkg::hdr_len_t len,
                                                logic [7:0] seed);
    logic [7:0] raw;
    logic [7:0] sum;
    raw = {kind, len};
    sum = 8'd0;
    for (int i = 0; i < int'(len); i++) begin
      sum = sum + seed + 8'(i);
    end
    return {raw, sum};
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic kind_check(string name, frame_pkg::hdr_kind_t got,
                            frame_pkg::hdr_kind_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic raw_check(string name, logic [frame_pkg::byte_width-1:0] got,
                           logic [frame_pkg::byte_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic len_check(string name, frame_pkg::hdr_len_t got, frame_pkg::hdr_len_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic count_check(string name, logic [$bits(frame_pkg::hdr_len_t):0] got,
                             logic [$bits(frame_pkg::hdr_len_t):0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic sum_check(string name, frame_pkg::sum_t got, frame_pkg::sum_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic flag_check(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Issue one command once the generator is idle
  task automatic send_cmd(frame_pkg::hdr_kind_t kind, frame_pkg::hdr_len_t len,
                          logic [7:0] seed, logic bad);
    @(posedge clk);
    while (gen_busy) begin
      @(posedge clk);
    end
    cmd_valid <= 1'b1;
    cmd_kind  <= kind;
    cmd_len   <= len;
    cmd_seed  <= seed;
    cmd_bad   <= bad;
    // Delivered only if good and no longer than the 16-entry memory
    if (!bad && len < 6'd16) begin
      exp_q.push_back(expect_result(kind, len, seed));
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    case (ready_mode)
      2'd0:    sink_ready <= 1'b0;
      2'd1:    sink_ready <= 1'b1;
      default: sink_ready <= 1'($urandom % 2);
    endcase
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle_count);
      stop_run();
    end
  end

  // Compare every result with the head of the expected queue
  always @(posedge clk) begin
    if (!rst && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("Result at %0t ns when no frame was expected", $time);
        stop_run();
      end else begin
        head = exp_q.pop_front();
        kind_check("res_kind", res_kind, frame_pkg::hdr_kind_t'(head[15:14]));
        raw_check("res_hdr_raw", res_hdr_raw, head[15:8]);
        len_check("res_len", res_len, head[13:8]);
        count_check("res_count", res_count, {1'b0, head[13:8]});
        sum_check("res_sum", res_sum, head[7:0]);
        flag_check("res_len_err", res_len_err, 1'b0);
      end
    end
  end

  initial begin
    int unsigned rnd;
    logic        drop_seen;
    rnd = $urandom(5736);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    flag_check("res_valid", res_valid, 1'b0);
    flag_check("drop_frame", drop_frame, 1'b0);
    flag_check("gen_busy", gen_busy, 1'b0);
    repeat (5) @(posedge clk);

    for (int i = 0; i < 15; i++) begin
      send_cmd(frame_pkg::hdr_kind_t'(2'(i % 3)), 6'(i), 8'(i * 17 + 3), 1'b0);
      wait_drain();
    end

    // Bad frames leave no trace
    send_cmd(frame_pkg::KIND_TAGGED, 6'd5, 8'h40, 1'b1);
    send_cmd(frame_pkg::KIND_PLAIN, 6'd0, 8'h00, 1'b1);
    send_cmd(frame_pkg::KIND_PRIORITY, 6'd7, 8'hf0, 1'b0);
    wait_drain();

    send_cmd(frame_pkg::KIND_PLAIN, 6'd20, 8'h11, 1'b0);
    drop_seen = 1'b0;
    @(posedge clk);
    while (gen_busy) begin
      if (drop_frame) drop_seen = 1'b1;
      @(posedge clk);
    end
    if (!drop_seen) begin
      $display("drop_frame never rose while the oversize frame streamed in");
      stop_run();
    end
    send_cmd(frame_pkg::KIND_TAGGED, 6'd2, 8'h80, 1'b0);
    wait_drain();

    // Frames pile up in the FIFO while the sink stalls
    ready_mode <= 2'd0;
    send_cmd(frame_pkg::KIND_PLAIN, 6'd3, 8'h21, 1'b0);
    send_cmd(frame_pkg::KIND_TAGGED, 6'd4, 8'hfe, 1'b0);
    send_cmd(frame_pkg::KIND_PRIORITY, 6'd2, 8'h07, 1'b0);
    send_cmd(frame_pkg::KIND_PLAIN, 6'd1, 8'h99, 1'b0);
    repeat (12) @(posedge clk);
    if (exp_q.size() != 4) begin
      $display("A result came out while sink_ready was held low");
      stop_run();
    end
    ready_mode <= 2'd1;
    wait_drain();

    ready_mode <= 2'd2;
    for (int i = 0; i < 30; i++) begin
      rnd = $urandom;
      send_cmd(frame_pkg::hdr_kind_t'(2'(rnd % 3)), {2'b00, rnd[11:8]}, rnd[23:16],
               rnd[31:29] == 3'd0);
      wait_drain();
    end

    ready_mode <= 2'd1;
    repeat (20) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("%0d expected results never arrived", exp_q.size());
      stop_run();
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
frame_pkg.sv
frame_gen.sv
axis_frame_fifo.sv
frame_sink.sv
frame_path.sv
frame_path_sva.sv
tb_frame_path.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the frame path testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module tb_frame_path -o sim_frame_path
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/sim_frame_path > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
